// File: rtl/dispatch_pkg.sv
package dispatch_pkg;

	localparam int WORD_W = 32;
	localparam int REG_PTR_W = 5;
	localparam int CMD_W = 5;
	localparam int GR_COUNT = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_PTR_W-1:0] reg_ptr_t;
	typedef logic [CMD_W-1:0] cmd_t;

	// System register numbers
	localparam reg_ptr_t SYSREG_TIDR = 5'd2;
	localparam reg_ptr_t SYSREG_SPR = 5'd4;
	localparam reg_ptr_t SYSREG_PSR = 5'd5;
	localparam reg_ptr_t SYSREG_PPSR = 5'd12;
	localparam reg_ptr_t SYSREG_PPCR = 5'd13;

	// PSR fields dropped on interrupt entry
	localparam int PSR_IM_BIT = 2;
	localparam int PSR_CMOD_LO_BIT = 5;
	localparam int PSR_CMOD_HI_BIT = 6;

	localparam word_t PSR_IRQ_CLEAR_MASK = word_t'(
		(1 << PSR_CMOD_HI_BIT) |
		(1 << PSR_CMOD_LO_BIT) |
		(1 << PSR_IM_BIT)
	);

	// Source 1 is an immediate or a register pointer in the low bits
	typedef union packed {
		word_t imm;
		struct packed {
			logic [WORD_W-REG_PTR_W-1:0] unused;
			reg_ptr_t ptr;
		} regs;
	} src1_field_u;

endpackage

// File: rtl/general_register_file.sv
`timescale 1ns/10ps

module general_register_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_destination_sysreg,
	input dispatch_pkg::reg_ptr_t wb_destination,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::reg_ptr_t read0_ptr,
	input dispatch_pkg::reg_ptr_t read1_ptr,
	output dispatch_pkg::word_t read0_data,
	output dispatch_pkg::word_t read1_data
);

	dispatch_pkg::word_t gr [dispatch_pkg::GR_COUNT];
	logic write_en;

	assign write_en = wb_valid && wb_writeback && !wb_destination_sysreg && !pipeline_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < dispatch_pkg::GR_COUNT; i++) begin
				gr[i] <= '0;
			end
		end else if (write_en) begin
			gr[wb_destination] <= wb_data;
		end
	end

	// Reads see the old contents until the edge
	assign read0_data = gr[read0_ptr];
	assign read1_data = gr[read1_ptr];

endmodule

// File: rtl/system_register_file.sv
`timescale 1ns/10ps

module system_register_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic irq_set,
	input logic irq_clr,
	input logic ppcr_set,
	input dispatch_pkg::word_t ppcr_data,
	input logic wb_valid,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::reg_ptr_t wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input dispatch_pkg::word_t wb_spr,
	input dispatch_pkg::reg_ptr_t read0_ptr,
	input dispatch_pkg::reg_ptr_t read1_ptr,
	output dispatch_pkg::word_t read0_data,
	output dispatch_pkg::word_t read1_data,
	output dispatch_pkg::word_t tidr,
	output dispatch_pkg::word_t spr,
	output dispatch_pkg::word_t psr,
	output dispatch_pkg::word_t ppsr,
	output dispatch_pkg::word_t ppcr
);

	logic wb_sys_write;
	logic spr_side_write;

	assign wb_sys_write = wb_valid && wb_writeback && wb_destination_sysreg && !pipeline_stop;
	assign spr_side_write = wb_valid && wb_spr_writeback && !pipeline_stop;

	function automatic dispatch_pkg::word_t read_sysreg(input dispatch_pkg::reg_ptr_t num);
		case (num)
			dispatch_pkg::SYSREG_TIDR: return tidr;
			dispatch_pkg::SYSREG_SPR: return spr;
			dispatch_pkg::SYSREG_PSR: return psr;
			dispatch_pkg::SYSREG_PPSR: return ppsr;
			dispatch_pkg::SYSREG_PPCR: return ppcr;
			default: return '0;
		endcase
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
			ppcr <= '0;
		end else begin
			if (wb_sys_write && wb_destination == dispatch_pkg::SYSREG_TIDR) begin
				tidr <= wb_data;
			end
			// Stack pointer side channel wins over the data bus
			if (spr_side_write) begin
				spr <= wb_spr;
			end else if (wb_sys_write && wb_destination == dispatch_pkg::SYSREG_SPR) begin
				spr <= wb_data;
			end
			if (irq_set) begin
				psr <= psr & ~dispatch_pkg::PSR_IRQ_CLEAR_MASK;
			end else if (irq_clr) begin
				psr <= ppsr;
			end else if (wb_sys_write && wb_destination == dispatch_pkg::SYSREG_PSR) begin
				psr <= wb_data;
			end
			// Interrupt entry saves the old PSR
			if (irq_set) begin
				ppsr <= psr;
			end else if (wb_sys_write && wb_destination == dispatch_pkg::SYSREG_PPSR) begin
				ppsr <= wb_data;
			end
			if (ppcr_set) begin
				ppcr <= ppcr_data;
			end else if (wb_sys_write && wb_destination == dispatch_pkg::SYSREG_PPCR) begin
				ppcr <= wb_data;
			end
		end
	end

	always_comb begin
		read0_data = read_sysreg(read0_ptr);
		read1_data = read_sysreg(read1_ptr);
	end

endmodule

// File: rtl/writeback_forward.sv
`timescale 1ns/10ps

module writeback_forward (
	input dispatch_pkg::reg_ptr_t source0_ptr,
	input logic source0_sysreg,
	input dispatch_pkg::src1_field_u source1,
	input logic source1_imm,
	input logic source1_sysreg,
	input logic wb_valid,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::reg_ptr_t wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input dispatch_pkg::word_t wb_spr,
	output logic forward0_hit,
	output logic forward1_hit,
	output dispatch_pkg::word_t forward0_data,
	output dispatch_pkg::word_t forward1_data
);

	// SPR side channel seen from a system source
	function automatic logic spr_match(input dispatch_pkg::reg_ptr_t ptr, input logic sysreg);
		return wb_valid && wb_spr_writeback && sysreg && ptr == dispatch_pkg::SYSREG_SPR;
	endfunction

	function automatic logic data_match(input dispatch_pkg::reg_ptr_t ptr, input logic sysreg);
		return wb_valid && wb_writeback && ptr == wb_destination &&
			sysreg == wb_destination_sysreg;
	endfunction

	function automatic dispatch_pkg::word_t match_data(
		input dispatch_pkg::reg_ptr_t ptr,
		input logic sysreg
	);
		if (spr_match(ptr, sysreg)) begin
			return wb_spr;
		end
		return wb_data;
	endfunction

	always_comb begin
		forward0_hit = spr_match(source0_ptr, source0_sysreg) ||
			data_match(source0_ptr, source0_sysreg);
		forward0_data = match_data(source0_ptr, source0_sysreg);
		// An immediate never matches
		forward1_hit = !source1_imm &&
			(spr_match(source1.regs.ptr, source1_sysreg) ||
			data_match(source1.regs.ptr, source1_sysreg));
		forward1_data = match_data(source1.regs.ptr, source1_sysreg);
	end

endmodule

// File: rtl/operand_latch.sv
`timescale 1ns/10ps

module operand_latch (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic prev_valid,
	input dispatch_pkg::cmd_t prev_cmd,
	input dispatch_pkg::reg_ptr_t prev_destination,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input logic prev_source0_sysreg,
	input dispatch_pkg::src1_field_u prev_source1,
	input logic prev_source1_imm,
	input logic prev_source1_sysreg,
	input dispatch_pkg::word_t prev_pc,
	input logic forward0_hit,
	input logic forward1_hit,
	input dispatch_pkg::word_t forward0_data,
	input dispatch_pkg::word_t forward1_data,
	input dispatch_pkg::word_t gr0_data,
	input dispatch_pkg::word_t gr1_data,
	input dispatch_pkg::word_t sys0_data,
	input dispatch_pkg::word_t sys1_data,
	output logic next_valid,
	output dispatch_pkg::cmd_t next_cmd,
	output dispatch_pkg::reg_ptr_t next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output dispatch_pkg::word_t next_source0,
	output dispatch_pkg::word_t next_source1,
	output dispatch_pkg::word_t next_pc
);

	logic valid_q;
	dispatch_pkg::word_t source0_sel;
	dispatch_pkg::word_t source1_sel;

	always_comb begin
		if (forward0_hit) begin
			source0_sel = forward0_data;
		end else if (prev_source0_sysreg) begin
			source0_sel = sys0_data;
		end else begin
			source0_sel = gr0_data;
		end
	end

	// Immediate first, then write-back, then the files
	always_comb begin
		if (prev_source1_imm) begin
			source1_sel = prev_source1.imm;
		end else if (forward1_hit) begin
			source1_sel = forward1_data;
		end else if (prev_source1_sysreg) begin
			source1_sel = sys1_data;
		end else begin
			source1_sel = gr1_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			next_cmd <= '0;
			next_destination <= '0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0 <= '0;
			next_source1 <= '0;
			next_pc <= '0;
		end else if (refresh) begin
			valid_q <= 1'b0;
			next_cmd <= '0;
			next_destination <= '0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0 <= '0;
			next_source1 <= '0;
			next_pc <= '0;
		end else if (!next_lock) begin
			valid_q <= prev_valid;
			next_cmd <= prev_cmd;
			next_destination <= prev_destination;
			next_destination_sysreg <= prev_destination_sysreg;
			next_writeback <= prev_writeback;
			next_source0 <= source0_sel;
			next_source1 <= source1_sel;
			next_pc <= prev_pc;
		end
	end

	// Held instruction stays hidden while execute is locked
	assign next_valid = valid_q && !next_lock;

endmodule

// File: rtl/dispatch.sv
`timescale 1ns/10ps

module dispatch (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic refresh,
	input logic irq_set,
	input logic irq_clr,
	input logic ppcr_set,
	input dispatch_pkg::word_t ppcr_data,
	input logic prev_valid,
	input dispatch_pkg::cmd_t prev_cmd,
	input dispatch_pkg::reg_ptr_t prev_destination,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input dispatch_pkg::reg_ptr_t prev_source0,
	input logic prev_source0_sysreg,
	input dispatch_pkg::src1_field_u prev_source1,
	input logic prev_source1_imm,
	input logic prev_source1_sysreg,
	input dispatch_pkg::word_t prev_pc,
	output logic previous_lock,
	output logic next_valid,
	output dispatch_pkg::cmd_t next_cmd,
	output dispatch_pkg::reg_ptr_t next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output dispatch_pkg::word_t next_source0,
	output dispatch_pkg::word_t next_source1,
	output dispatch_pkg::word_t next_pc,
	input logic next_lock,
	input logic wb_valid,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::reg_ptr_t wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input dispatch_pkg::word_t wb_spr,
	output dispatch_pkg::word_t sysreg_tidr,
	output dispatch_pkg::word_t sysreg_spr,
	output dispatch_pkg::word_t sysreg_psr,
	output dispatch_pkg::word_t sysreg_ppsr,
	output dispatch_pkg::word_t sysreg_ppcr
);

	dispatch_pkg::reg_ptr_t source1_ptr;
	dispatch_pkg::word_t gr0_data;
	dispatch_pkg::word_t gr1_data;
	dispatch_pkg::word_t sys0_data;
	dispatch_pkg::word_t sys1_data;
	logic forward0_hit;
	logic forward1_hit;
	dispatch_pkg::word_t forward0_data;
	dispatch_pkg::word_t forward1_data;

	assign source1_ptr = prev_source1.regs.ptr;

	// Decoder stalls together with this stage
	assign previous_lock = next_lock;

	general_register_file i_general_register_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.pipeline_stop(pipeline_stop),
		.wb_valid(wb_valid),
		.wb_writeback(wb_writeback),
		.wb_destination_sysreg(wb_destination_sysreg),
		.wb_destination(wb_destination),
		.wb_data(wb_data),
		.read0_ptr(prev_source0),
		.read1_ptr(source1_ptr),
		.read0_data(gr0_data),
		.read1_data(gr1_data)
	);

	system_register_file i_system_register_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.pipeline_stop(pipeline_stop),
		.irq_set(irq_set),
		.irq_clr(irq_clr),
		.ppcr_set(ppcr_set),
		.ppcr_data(ppcr_data),
		.wb_valid(wb_valid),
		.wb_data(wb_data),
		.wb_destination(wb_destination),
		.wb_destination_sysreg(wb_destination_sysreg),
		.wb_writeback(wb_writeback),
		.wb_spr_writeback(wb_spr_writeback),
		.wb_spr(wb_spr),
		.read0_ptr(prev_source0),
		.read1_ptr(source1_ptr),
		.read0_data(sys0_data),
		.read1_data(sys1_data),
		.tidr(sysreg_tidr),
		.spr(sysreg_spr),
		.psr(sysreg_psr),
		.ppsr(sysreg_ppsr),
		.ppcr(sysreg_ppcr)
	);

	writeback_forward i_writeback_forward (
		.source0_ptr(prev_source0),
		.source0_sysreg(prev_source0_sysreg),
		.source1(prev_source1),
		.source1_imm(prev_source1_imm),
		.source1_sysreg(prev_source1_sysreg),
		.wb_valid(wb_valid),
		.wb_data(wb_data),
		.wb_destination(wb_destination),
		.wb_destination_sysreg(wb_destination_sysreg),
		.wb_writeback(wb_writeback),
		.wb_spr_writeback(wb_spr_writeback),
		.wb_spr(wb_spr),
		.forward0_hit(forward0_hit),
		.forward1_hit(forward1_hit),
		.forward0_data(forward0_data),
		.forward1_data(forward1_data)
	);

	operand_latch i_operand_latch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.refresh(refresh),
		.next_lock(next_lock),
		.prev_valid(prev_valid),
		.prev_cmd(prev_cmd),
		.prev_destination(prev_destination),
		.prev_destination_sysreg(prev_destination_sysreg),
		.prev_writeback(prev_writeback),
		.prev_source0_sysreg(prev_source0_sysreg),
		.prev_source1(prev_source1),
		.prev_source1_imm(prev_source1_imm),
		.prev_source1_sysreg(prev_source1_sysreg),
		.prev_pc(prev_pc),
		.forward0_hit(forward0_hit),
		.forward1_hit(forward1_hit),
		.forward0_data(forward0_data),
		.forward1_data(forward1_data),
		.gr0_data(gr0_data),
		.gr1_data(gr1_data),
		.sys0_data(sys0_data),
		.sys1_data(sys1_data),
		.next_valid(next_valid),
		.next_cmd(next_cmd),
		.next_destination(next_destination),
		.next_destination_sysreg(next_destination_sysreg),
		.next_writeback(next_writeback),
		.next_source0(next_source0),
		.next_source1(next_source1),
		.next_pc(next_pc)
	);

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic iCLOCK,
	output logic inRESET
);

	// 4 ns period
	initial begin
		iCLOCK = 1'b0;
		forever begin
			#2 iCLOCK = ~iCLOCK;
		end
	end

	// Reset held low for three rising edges
	initial begin
		inRESET <= 1'b0;
		repeat (3) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

// File: test/dispatch_sva.sv
`timescale 1ns/10ps

module dispatch_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic next_lock,
	input logic next_valid,
	input logic previous_lock
);

	// Execute never sees a valid while it holds the lock
	lock_hides_valid: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) next_lock |-> !next_valid
	) else $error("next_valid high while next_lock is high");

	lock_passed_upstream: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) previous_lock == next_lock
	) else $error("previous_lock differs from next_lock");

	// Stage is empty one edge after refresh
	refresh_empties: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) refresh |=> !next_valid
	) else $error("next_valid high in the cycle after refresh");

endmodule

bind dispatch dispatch_sva i_dispatch_sva (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.refresh(refresh),
	.next_lock(next_lock),
	.next_valid(next_valid),
	.previous_lock(previous_lock)
);

// File: test/tb_dispatch.sv
`timescale 1ns/10ps

module tb_dispatch;

	logic iCLOCK;
	logic inRESET;
	logic pipeline_stop;
	logic refresh;
	logic irq_set;
	logic irq_clr;
	logic ppcr_set;
	dispatch_pkg::word_t ppcr_data;
	logic prev_valid;
	dispatch_pkg::cmd_t prev_cmd;
	dispatch_pkg::reg_ptr_t prev_destination;
	logic prev_destination_sysreg;
	logic prev_writeback;
	dispatch_pkg::reg_ptr_t prev_source0;
	logic prev_source0_sysreg;
	dispatch_pkg::src1_field_u prev_source1;
	logic prev_source1_imm;
	logic prev_source1_sysreg;
	dispatch_pkg::word_t prev_pc;
	logic previous_lock;
	logic next_valid;
	dispatch_pkg::cmd_t next_cmd;
	dispatch_pkg::reg_ptr_t next_destination;
	logic next_destination_sysreg;
	logic next_writeback;
	dispatch_pkg::word_t next_source0;
	dispatch_pkg::word_t next_source1;
	dispatch_pkg::word_t next_pc;
	logic next_lock;
	logic wb_valid;
	dispatch_pkg::word_t wb_data;
	dispatch_pkg::reg_ptr_t wb_destination;
	logic wb_destination_sysreg;
	logic wb_writeback;
	logic wb_spr_writeback;
	dispatch_pkg::word_t wb_spr;
	dispatch_pkg::word_t sysreg_tidr;
	dispatch_pkg::word_t sysreg_spr;
	dispatch_pkg::word_t sysreg_psr;
	dispatch_pkg::word_t sysreg_ppsr;
	dispatch_pkg::word_t sysreg_ppcr;

	// Reference model of the register state
	dispatch_pkg::word_t gr_model [32];
	dispatch_pkg::word_t m_tidr;
	dispatch_pkg::word_t m_spr;
	dispatch_pkg::word_t m_psr;
	dispatch_pkg::word_t m_ppsr;
	dispatch_pkg::word_t m_ppcr;

	dispatch_pkg::cmd_t inst_cmd;
	dispatch_pkg::reg_ptr_t inst_dest;
	logic inst_dest_sys;
	logic inst_writeback;
	dispatch_pkg::word_t inst_pc;
	integer seed;
	int check_errors;
	int timeout_errors;

	tb_clock i_tb_clock (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	dispatch i_dispatch (.*);

	task automatic check_word(input string name, input dispatch_pkg::word_t got,
		input dispatch_pkg::word_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_ptr(input string name, input dispatch_pkg::reg_ptr_t got,
		input dispatch_pkg::reg_ptr_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_cmd(input string name, input dispatch_pkg::cmd_t got,
		input dispatch_pkg::cmd_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_sysregs;
		check_word("sysreg_tidr", sysreg_tidr, m_tidr);
		check_word("sysreg_spr", sysreg_spr, m_spr);
		check_word("sysreg_psr", sysreg_psr, m_psr);
		check_word("sysreg_ppsr", sysreg_ppsr, m_ppsr);
		check_word("sysreg_ppcr", sysreg_ppcr, m_ppcr);
	endtask

	// Register view with noise in the unused bits
	function automatic dispatch_pkg::src1_field_u reg_field(input dispatch_pkg::reg_ptr_t ptr);
		dispatch_pkg::src1_field_u f;
		f.regs.unused = 27'($random(seed));
		f.regs.ptr = ptr;
		return f;
	endfunction

	task automatic wait_reset_release;
		int n;
		n = 0;
		while (inRESET !== 1'b1 && n < 20) begin
			@(posedge iCLOCK);
			n++;
		end
		if (inRESET !== 1'b1) begin
			timeout_errors++;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic wait_valid(output logic seen);
		seen = 1'b0;
		for (int n = 0; n < 20 && !seen; n++) begin
			@(negedge iCLOCK);
			seen = (next_valid === 1'b1);
		end
		if (!seen) begin
			timeout_errors++;
			$display("Timeout: no instruction reached execute within 20 cycles");
		end
	endtask

	task automatic release_strobes;
		prev_valid <= 1'b0;
		wb_valid <= 1'b0;
		wb_writeback <= 1'b0;
		wb_spr_writeback <= 1'b0;
		pipeline_stop <= 1'b0;
		irq_set <= 1'b0;
		irq_clr <= 1'b0;
		ppcr_set <= 1'b0;
		refresh <= 1'b0;
	endtask

	// One cycle of write-back and control strobes, mirrored into the model
	task automatic apply_strobes(
		input logic wv, input logic ww, input dispatch_pkg::reg_ptr_t dest, input logic dsys,
		input dispatch_pkg::word_t data, input logic sw, input dispatch_pkg::word_t sdata,
		input logic stop, input logic iset, input logic iclr, input logic pset,
		input dispatch_pkg::word_t pdata
	);
		dispatch_pkg::word_t old_psr;
		logic sys_write;
		old_psr = m_psr;
		sys_write = wv && ww && dsys && !stop;
		wb_valid <= wv;
		wb_writeback <= ww;
		wb_destination <= dest;
		wb_destination_sysreg <= dsys;
		wb_data <= data;
		wb_spr_writeback <= sw;
		wb_spr <= sdata;
		pipeline_stop <= stop;
		irq_set <= iset;
		irq_clr <= iclr;
		ppcr_set <= pset;
		ppcr_data <= pdata;
		if (wv && ww && !dsys && !stop) begin
			gr_model[dest] = data;
		end
		if (sys_write && dest == dispatch_pkg::SYSREG_TIDR) begin
			m_tidr = data;
		end
		if (wv && sw && !stop) begin
			m_spr = sdata;
		end else if (sys_write && dest == dispatch_pkg::SYSREG_SPR) begin
			m_spr = data;
		end
		// Interrupt entry clears bits 6, 5 and 2
		if (iset) begin
			m_psr = old_psr & ~32'h0000_0064;
			m_ppsr = old_psr;
		end else begin
			if (iclr) begin
				m_psr = m_ppsr;
			end else if (sys_write && dest == dispatch_pkg::SYSREG_PSR) begin
				m_psr = data;
			end
			if (sys_write && dest == dispatch_pkg::SYSREG_PPSR) begin
				m_ppsr = data;
			end
		end
		if (pset) begin
			m_ppcr = pdata;
		end else if (sys_write && dest == dispatch_pkg::SYSREG_PPCR) begin
			m_ppcr = data;
		end
	endtask

	task automatic write_reg(input dispatch_pkg::reg_ptr_t num, input logic sys,
		input dispatch_pkg::word_t data);
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b1, num, sys, data, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		@(posedge iCLOCK);
		release_strobes();
	endtask

	task automatic drive_instr(
		input dispatch_pkg::reg_ptr_t src0, input logic src0_sys,
		input dispatch_pkg::src1_field_u src1, input logic src1_imm, input logic src1_sys
	);
		inst_cmd = dispatch_pkg::cmd_t'($random(seed));
		inst_dest = dispatch_pkg::reg_ptr_t'($random(seed));
		inst_dest_sys = 1'($random(seed));
		inst_writeback = 1'($random(seed));
		inst_pc = dispatch_pkg::word_t'($random(seed));
		prev_valid <= 1'b1;
		prev_cmd <= inst_cmd;
		prev_destination <= inst_dest;
		prev_destination_sysreg <= inst_dest_sys;
		prev_writeback <= inst_writeback;
		prev_source0 <= src0;
		prev_source0_sysreg <= src0_sys;
		prev_source1 <= src1;
		prev_source1_imm <= src1_imm;
		prev_source1_sysreg <= src1_sys;
		prev_pc <= inst_pc;
	endtask

	task automatic expect_dispatch(input dispatch_pkg::word_t exp0,
		input dispatch_pkg::word_t exp1);
		logic seen;
		wait_valid(seen);
		if (seen) begin
			check_cmd("next_cmd", next_cmd, inst_cmd);
			check_ptr("next_destination", next_destination, inst_dest);
			check_bit("next_destination_sysreg", next_destination_sysreg, inst_dest_sys);
			check_bit("next_writeback", next_writeback, inst_writeback);
			check_word("next_source0", next_source0, exp0);
			check_word("next_source1", next_source1, exp1);
			check_word("next_pc", next_pc, inst_pc);
		end
	endtask

	task automatic dispatch_and_check(
		input dispatch_pkg::reg_ptr_t src0, input logic src0_sys,
		input dispatch_pkg::src1_field_u src1, input logic src1_imm, input logic src1_sys,
		input dispatch_pkg::word_t exp0, input dispatch_pkg::word_t exp1
	);
		@(posedge iCLOCK);
		drive_instr(src0, src0_sys, src1, src1_imm, src1_sys);
		@(posedge iCLOCK);
		release_strobes();
		expect_dispatch(exp0, exp1);
	endtask

	task automatic reset_state;
		@(negedge iCLOCK);
		check_bit("next_valid", next_valid, 1'b0);
		check_bit("previous_lock", previous_lock, 1'b0);
		check_word("next_source0", next_source0, '0);
		check_word("next_pc", next_pc, '0);
		compare_sysregs();
	endtask

	task automatic register_reads;
		dispatch_pkg::src1_field_u f;
		for (int i = 0; i < 32; i++) begin
			write_reg(dispatch_pkg::reg_ptr_t'(i), 1'b0, dispatch_pkg::word_t'($random(seed)));
		end
		dispatch_and_check(5'd3, 1'b0, reg_field(5'd17), 1'b0, 1'b0, gr_model[3], gr_model[17]);
		f.imm = dispatch_pkg::word_t'($random(seed));
		dispatch_and_check(5'd31, 1'b0, f, 1'b1, 1'b0, gr_model[31], f.imm);
	endtask

	task automatic writeback_forwarding;
		dispatch_pkg::word_t value;
		dispatch_pkg::word_t old_value;
		value = dispatch_pkg::word_t'($random(seed));
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b1, 5'd7, 1'b0, value, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		drive_instr(5'd7, 1'b0, reg_field(5'd7), 1'b0, 1'b0);
		@(posedge iCLOCK);
		release_strobes();
		expect_dispatch(value, value);
		// Stack pointer side channel
		value = dispatch_pkg::word_t'($random(seed));
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b0, 5'd0, 1'b0, '0, 1'b1, value, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		drive_instr(dispatch_pkg::SYSREG_SPR, 1'b1, reg_field(dispatch_pkg::SYSREG_SPR),
			1'b0, 1'b1);
		@(posedge iCLOCK);
		release_strobes();
		expect_dispatch(value, value);
		check_word("sysreg_spr", sysreg_spr, value);
		// Stopped write is forwarded but never lands
		old_value = gr_model[9];
		value = dispatch_pkg::word_t'($random(seed));
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b1, 5'd9, 1'b0, value, 1'b0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		drive_instr(5'd9, 1'b0, reg_field(5'd9), 1'b0, 1'b0);
		@(posedge iCLOCK);
		release_strobes();
		expect_dispatch(value, value);
		dispatch_and_check(5'd9, 1'b0, reg_field(5'd9), 1'b0, 1'b0, old_value, old_value);
	endtask

	task automatic system_updates;
		write_reg(dispatch_pkg::SYSREG_TIDR, 1'b1, dispatch_pkg::word_t'($random(seed)));
		write_reg(dispatch_pkg::SYSREG_PSR, 1'b1, $random(seed) | 32'h0000_0064);
		@(negedge iCLOCK);
		compare_sysregs();
		// External load beats the PPCR write-back
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b1, dispatch_pkg::SYSREG_PPCR, 1'b1, $random(seed), 1'b0, '0,
			1'b0, 1'b0, 1'b0, 1'b1, $random(seed));
		@(posedge iCLOCK);
		release_strobes();
		@(negedge iCLOCK);
		compare_sysregs();
		// Interrupt entry beats the PSR write-back
		@(posedge iCLOCK);
		apply_strobes(1'b1, 1'b1, dispatch_pkg::SYSREG_PSR, 1'b1, $random(seed), 1'b0, '0,
			1'b0, 1'b1, 1'b0, 1'b0, '0);
		@(posedge iCLOCK);
		release_strobes();
		@(negedge iCLOCK);
		compare_sysregs();
		check_word("sysreg_psr masked bits", sysreg_psr & 32'h0000_0064, '0);
		write_reg(dispatch_pkg::SYSREG_PSR, 1'b1, dispatch_pkg::word_t'($random(seed)));
		@(posedge iCLOCK);
		apply_strobes(1'b0, 1'b0, 5'd0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0, 1'b1, 1'b0, '0);
		@(posedge iCLOCK);
		release_strobes();
		@(negedge iCLOCK);
		compare_sysregs();
		dispatch_and_check(dispatch_pkg::SYSREG_PSR, 1'b1, reg_field(dispatch_pkg::SYSREG_PPSR),
			1'b0, 1'b1, m_psr, m_ppsr);
		dispatch_and_check(dispatch_pkg::SYSREG_PPCR, 1'b1, reg_field(dispatch_pkg::SYSREG_SPR),
			1'b0, 1'b1, m_ppcr, m_spr);
		// Number 7 is not a system register
		dispatch_and_check(dispatch_pkg::SYSREG_TIDR, 1'b1, reg_field(5'd7), 1'b0, 1'b1,
			m_tidr, '0);
	endtask

	task automatic lock_and_refresh;
		dispatch_pkg::src1_field_u f;
		dispatch_pkg::word_t held0;
		dispatch_pkg::word_t held1;
		dispatch_pkg::word_t held_pc;
		held0 = gr_model[4];
		held1 = gr_model[12];
		@(posedge iCLOCK);
		drive_instr(5'd4, 1'b0, reg_field(5'd12), 1'b0, 1'b0);
		held_pc = inst_pc;
		@(posedge iCLOCK);
		// First instruction latched while the second waits behind the lock
		next_lock <= 1'b1;
		f.imm = dispatch_pkg::word_t'($random(seed));
		drive_instr(5'd5, 1'b0, f, 1'b1, 1'b0);
		for (int n = 0; n < 3; n++) begin
			@(negedge iCLOCK);
			check_bit("next_valid", next_valid, 1'b0);
			check_bit("previous_lock", previous_lock, 1'b1);
			check_word("next_source0", next_source0, held0);
			check_word("next_source1", next_source1, held1);
			check_word("next_pc", next_pc, held_pc);
		end
		@(posedge iCLOCK);
		next_lock <= 1'b0;
		@(negedge iCLOCK);
		check_bit("next_valid", next_valid, 1'b1);
		check_bit("previous_lock", previous_lock, 1'b0);
		check_word("next_source0", next_source0, held0);
		check_word("next_pc", next_pc, held_pc);
		@(posedge iCLOCK);
		release_strobes();
		expect_dispatch(gr_model[5], f.imm);
		@(posedge iCLOCK);
		drive_instr(5'd6, 1'b0, reg_field(5'd8), 1'b0, 1'b0);
		@(posedge iCLOCK);
		// Refresh wins over the load presented at the same edge
		refresh <= 1'b1;
		drive_instr(5'd10, 1'b0, reg_field(5'd11), 1'b0, 1'b0);
		@(negedge iCLOCK);
		check_bit("next_valid", next_valid, 1'b1);
		@(posedge iCLOCK);
		release_strobes();
		@(negedge iCLOCK);
		check_bit("next_valid", next_valid, 1'b0);
		check_word("next_source0", next_source0, '0);
		check_word("next_pc", next_pc, '0);
		check_ptr("next_destination", next_destination, '0);
	endtask

	initial begin
		seed = 9;
		check_errors = 0;
		timeout_errors = 0;
		for (int i = 0; i < 32; i++) begin
			gr_model[i] = '0;
		end
		m_tidr = '0;
		m_spr = '0;
		m_psr = '0;
		m_ppsr = '0;
		m_ppcr = '0;
		release_strobes();
		ppcr_data <= '0;
		prev_cmd <= '0;
		prev_destination <= '0;
		prev_destination_sysreg <= 1'b0;
		prev_writeback <= 1'b0;
		prev_source0 <= '0;
		prev_source0_sysreg <= 1'b0;
		prev_source1 <= '0;
		prev_source1_imm <= 1'b0;
		prev_source1_sysreg <= 1'b0;
		prev_pc <= '0;
		next_lock <= 1'b0;
		wb_data <= '0;
		wb_destination <= '0;
		wb_destination_sysreg <= 1'b0;
		wb_spr <= '0;
		wait_reset_release();
		reset_state();
		register_reads();
		writeback_forwarding();
		system_updates();
		lock_and_refresh();
		repeat (2) @(posedge iCLOCK);
		$display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: dispatch.f
rtl/dispatch_pkg.sv
rtl/general_register_file.sv
rtl/system_register_file.sv
rtl/writeback_forward.sv
rtl/operand_latch.sv
rtl/dispatch.sv
test/tb_clock.sv
test/dispatch_sva.sv
test/tb_dispatch.sv

// File: run.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_dispatch -f dispatch.f -o tb_dispatch
output=$(./obj_dir/tb_dispatch || true)
printf '%s\n' "$output"
echo "$output" | grep -qx "TESTBENCH PASSED"
